// ==== frogger_pkg.sv ====
`default_nettype none

package frogger_pkg;

    // Tile coordinate width
    localparam int POS_W = 6;

    // Hazard counts
    localparam int NUM_CARS = 5;
    localparam int NUM_LOGS = 3;

    // Row map of the field
    localparam int ROW_START    = 0;
    localparam int ROW_GOAL     = 11;
    localparam int ROW_RIVER_LO = 7;
    localparam int ROW_RIVER_HI = 9;
    localparam int ROW_TOP      = 11;

    // Cars spread over the road, one per row 1 to 5
    localparam logic [POS_W-1:0] CAR_X_INIT [NUM_CARS] = '{6'd0, 6'd3, 6'd6, 6'd9, 6'd12};
    localparam logic [POS_W-1:0] CAR_Y_INIT [NUM_CARS] = '{6'd1, 6'd2, 6'd3, 6'd4, 6'd5};

    // Logs on rows 7 to 9, x is the leading tile
    localparam logic [POS_W-1:0] LOG_X_INIT [NUM_LOGS] = '{6'd2, 6'd7, 6'd11};
    localparam logic [POS_W-1:0] LOG_Y_INIT [NUM_LOGS] = '{6'd7, 6'd8, 6'd9};

    // Log body trails behind the leading tile
    localparam int LOG_LEN = 3;

    // Game controller states
    typedef enum logic [1:0] {
        ST_PLAY,
        ST_DEAD,
        ST_OVER
    } game_state_t;

endpackage

`default_nettype wire

// ==== hazard_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface hazard_if
    import frogger_pkg::*;
();

    // Car tiles, one car per road row
    logic [POS_W-1:0] car_x [NUM_CARS];
    logic [POS_W-1:0] car_y [NUM_CARS];

    // Leading log tiles, one log per river row
    logic [POS_W-1:0] log_x [NUM_LOGS];
    logic [POS_W-1:0] log_y [NUM_LOGS];

    // Car mover side
    modport cars_src (output car_x, output car_y);

    // Log mover side
    modport logs_src (output log_x, output log_y);

    // Collision side sees the whole field
    modport sink (input car_x, input car_y, input log_x, input log_y);

endinterface

`default_nettype wire

// ==== hazard_mover.sv ====
`timescale 1ns/1ps
`default_nettype none

module hazard_mover
    import frogger_pkg::*;
#(
    parameter int GAME_WIDTH = 14,
    parameter int COUNT      = NUM_CARS,
    parameter bit IS_LOG     = 1'b0
) (
    input  logic i_Clk,
    input  logic i_rst_n,
    input  logic i_tick,
    hazard_if    hz
);

    // Last column before wrapping back to 0
    localparam logic [POS_W-1:0] LAST_X = POS_W'(GAME_WIDTH - 1);

    logic [POS_W-1:0] x_q [COUNT];

    // Start column from the matching package table
    function automatic logic [POS_W-1:0] init_x(input int idx);
        if (IS_LOG) begin
            return LOG_X_INIT[idx % NUM_LOGS];
        end
        return CAR_X_INIT[idx % NUM_CARS];
    endfunction

    // Fixed row of each object
    function automatic logic [POS_W-1:0] init_y(input int idx);
        if (IS_LOG) begin
            return LOG_Y_INIT[idx % NUM_LOGS];
        end
        return CAR_Y_INIT[idx % NUM_CARS];
    endfunction

    // Object count has to fit the bus arrays
    if (COUNT != (IS_LOG ? NUM_LOGS : NUM_CARS)) begin : g_count_check
        $error("hazard_mover COUNT does not match the hazard bus");
    end

    // All objects step right together on a tick
    always_ff @(posedge i_Clk) begin
        for (int i = 0; i < COUNT; i++) begin
            if (!i_rst_n) begin
                x_q[i] <= init_x(i);
            end else if (i_tick) begin
                x_q[i] <= (x_q[i] == LAST_X) ? '0 : x_q[i] + 1'b1;
            end
        end
    end

    // Drive only the half of the bus this mover owns
    if (IS_LOG) begin : g_log_bus
        for (genvar i = 0; i < COUNT; i++) begin : g_pos
            assign hz.log_x[i] = x_q[i];
            assign hz.log_y[i] = init_y(i);
        end
    end else begin : g_car_bus
        for (genvar i = 0; i < COUNT; i++) begin : g_pos
            assign hz.car_x[i] = x_q[i];
            assign hz.car_y[i] = init_y(i);
        end
    end

    // Wrap keeps every object inside the field
    for (genvar i = 0; i < COUNT; i++) begin : g_chk
        a_x_in_field: assert property (
            @(posedge i_Clk) disable iff (!i_rst_n) x_q[i] < GAME_WIDTH
        ) else $error("hazard %0d left the field at x %0d", i, x_q[i]);
    end

endmodule

`default_nettype wire

// ==== frog_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module frog_control
    import frogger_pkg::*;
#(
    parameter int GAME_WIDTH = 14
) (
    input  logic             i_Clk,
    input  logic             i_rst_n,
    input  logic             i_tick,
    input  logic             i_up,
    input  logic             i_down,
    input  logic             i_left,
    input  logic             i_right,
    input  logic             i_on_log,
    input  logic             i_respawn,
    input  logic             i_frozen,
    output logic [POS_W-1:0] o_frog_x,
    output logic [POS_W-1:0] o_frog_y
);

    // Origin sits mid field on the start row
    localparam logic [POS_W-1:0] ORIGIN_X = POS_W'(GAME_WIDTH / 2);
    localparam logic [POS_W-1:0] ORIGIN_Y = POS_W'(ROW_START);
    localparam logic [POS_W-1:0] LAST_X   = POS_W'(GAME_WIDTH - 1);
    localparam logic [POS_W-1:0] TOP_Y    = POS_W'(ROW_TOP);

    always_ff @(posedge i_Clk) begin
        if (!i_rst_n || i_respawn) begin
            o_frog_x <= ORIGIN_X;
            o_frog_y <= ORIGIN_Y;
        end else if (!i_frozen) begin
            // One button per cycle, blocked moves still eat the cycle
            if (i_up) begin
                if (o_frog_y != TOP_Y) begin
                    o_frog_y <= o_frog_y + 1'b1;
                end
            end else if (i_down) begin
                if (o_frog_y != ORIGIN_Y) begin
                    o_frog_y <= o_frog_y - 1'b1;
                end
            end else if (i_left) begin
                if (o_frog_x != '0) begin
                    o_frog_x <= o_frog_x - 1'b1;
                end
            end else if (i_right) begin
                if (o_frog_x != LAST_X) begin
                    o_frog_x <= o_frog_x + 1'b1;
                end
            end else if (i_tick && i_on_log) begin
                // Ride the log, wrap like the logs do
                o_frog_x <= (o_frog_x == LAST_X) ? '0 : o_frog_x + 1'b1;
            end
        end
    end

    // Frog stays within the row map
    a_frog_y_range: assert property (
        @(posedge i_Clk) disable iff (!i_rst_n) o_frog_y <= TOP_Y
    ) else $error("frog row %0d above the top row", o_frog_y);

endmodule

`default_nettype wire

// ==== frogger_collisions.sv ====
`timescale 1ns/1ps
`default_nettype none

module frogger_collisions
    import frogger_pkg::*;
#(
    parameter int GAME_WIDTH = 14
) (
    input  logic [POS_W-1:0] i_frog_x,
    input  logic [POS_W-1:0] i_frog_y,
    hazard_if.sink           hz,
    output logic             o_collided,
    output logic             o_on_log
);

    logic [NUM_CARS-1:0]              car_hit;
    logic [NUM_LOGS-1:0][LOG_LEN-1:0] log_tile;
    logic [NUM_LOGS-1:0]              log_sup;

    // a minus b around the field width
    function automatic logic [POS_W-1:0] wrap_sub(
        input logic [POS_W-1:0] a,
        input logic [POS_W-1:0] b
    );
        if (a >= b) begin
            return a - b;
        end
        return POS_W'(GAME_WIDTH) - (b - a);
    endfunction

    // Car hits the frog from either neighbouring tile
    for (genvar c = 0; c < NUM_CARS; c++) begin : g_car
        assign car_hit[c] = (i_frog_y == hz.car_y[c]) &&
                            ((i_frog_x == wrap_sub(hz.car_x[c], 1)) ||
                             (wrap_sub(i_frog_x, 1) == hz.car_x[c]));
    end

    // Log covers its leading tile and the tiles behind it
    for (genvar l = 0; l < NUM_LOGS; l++) begin : g_log
        for (genvar k = 0; k < LOG_LEN; k++) begin : g_tile
            assign log_tile[l][k] = (i_frog_x == wrap_sub(hz.log_x[l], POS_W'(k)));
        end
        assign log_sup[l] = (i_frog_y == hz.log_y[l]) && (|log_tile[l]);
    end

    assign o_collided = |car_hit;
    assign o_on_log   = |log_sup;

    // Log rows come from the package, so support only ever shows up in the river
    a_on_log_river: assert final (
        !o_on_log || ((i_frog_y >= ROW_RIVER_LO) && (i_frog_y <= ROW_RIVER_HI))
    ) else $error("on_log high on row %0d", i_frog_y);

endmodule

`default_nettype wire

// ==== frogger_game.sv ====
`timescale 1ns/1ps
`default_nettype none

module frogger_game
    import frogger_pkg::*;
#(
    parameter int START_LIVES = 3
) (
    input  logic             i_Clk,
    input  logic             i_rst_n,
    input  logic             i_start,
    input  logic             i_collided,
    input  logic             i_on_log,
    input  logic [POS_W-1:0] i_frog_y,
    output logic             o_respawn,
    output logic             o_frozen,
    output logic [1:0]       o_lives,
    output logic [7:0]       o_score,
    output game_state_t      o_state
);

    logic in_river;
    logic died;
    logic at_goal;

    // Water rows without a log under the frog drown it
    assign in_river = (i_frog_y >= POS_W'(ROW_RIVER_LO)) && (i_frog_y <= POS_W'(ROW_RIVER_HI));
    assign died     = i_collided || (in_river && !i_on_log);
    assign at_goal  = (i_frog_y == POS_W'(ROW_GOAL));

    always_ff @(posedge i_Clk) begin
        if (!i_rst_n) begin
            o_state <= ST_PLAY;
            o_lives <= 2'(START_LIVES);
            o_score <= '0;
        end else begin
            unique case (o_state)
                ST_PLAY: begin
                    if (died) begin
                        o_state <= ST_DEAD;
                        o_lives <= o_lives - 2'd1;
                    end else if (at_goal) begin
                        o_score <= o_score + 8'd1;
                    end
                end
                ST_DEAD: begin
                    // Last life gone, stay down
                    o_state <= (o_lives == 2'd0) ? ST_OVER : ST_PLAY;
                end
                ST_OVER: begin
                    if (i_start) begin
                        o_state <= ST_PLAY;
                        o_lives <= 2'(START_LIVES);
                        o_score <= '0;
                    end
                end
                default: o_state <= ST_PLAY;
            endcase
        end
    end

    // Frog back to origin after a death, a crossing or a restart
    always_comb begin
        unique case (o_state)
            ST_PLAY: o_respawn = at_goal && !died;
            ST_DEAD: o_respawn = (o_lives != 2'd0);
            ST_OVER: o_respawn = i_start;
            default: o_respawn = 1'b0;
        endcase
    end

    assign o_frozen = (o_state == ST_OVER);

    // Lives only refill through a restart
    a_lives_no_rise: assert property (
        @(posedge i_Clk) disable iff (!i_rst_n) (o_lives > $past(o_lives)) |-> $past(i_start)
    ) else $error("lives rose without start");

    // Frog lands at origin, so a respawn never repeats back to back
    a_respawn_pulse: assert property (
        @(posedge i_Clk) disable iff (!i_rst_n) o_respawn |=> !o_respawn
    ) else $error("respawn held for two cycles");

endmodule

`default_nettype wire

// ==== frogger_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module frogger_top
    import frogger_pkg::*;
#(
    parameter int GAME_WIDTH  = 14,
    parameter int START_LIVES = 3
) (
    input  logic             i_Clk,
    input  logic             i_rst_n,
    input  logic             i_tick,
    input  logic             i_up,
    input  logic             i_down,
    input  logic             i_left,
    input  logic             i_right,
    input  logic             i_start,
    output logic [POS_W-1:0] o_frog_x,
    output logic [POS_W-1:0] o_frog_y,
    output logic             o_collided,
    output logic             o_on_log,
    output logic [1:0]       o_lives,
    output logic [7:0]       o_score,
    output game_state_t      o_state
);

    logic [POS_W-1:0] frog_x;
    logic [POS_W-1:0] frog_y;
    logic             collided;
    logic             on_log;
    logic             respawn;
    logic             frozen;

    // Car and log positions
    hazard_if haz ();

    // Cars
    hazard_mover #(.GAME_WIDTH(GAME_WIDTH), .COUNT(NUM_CARS), .IS_LOG(1'b0)) u_cars (
        .i_Clk   (i_Clk),
        .i_rst_n (i_rst_n),
        .i_tick  (i_tick),
        .hz      (haz.cars_src)
    );

    // Logs
    hazard_mover #(.GAME_WIDTH(GAME_WIDTH), .COUNT(NUM_LOGS), .IS_LOG(1'b1)) u_logs (
        .i_Clk   (i_Clk),
        .i_rst_n (i_rst_n),
        .i_tick  (i_tick),
        .hz      (haz.logs_src)
    );

    frog_control #(.GAME_WIDTH(GAME_WIDTH)) u_frog (
        .i_Clk     (i_Clk),
        .i_rst_n   (i_rst_n),
        .i_tick    (i_tick),
        .i_up      (i_up),
        .i_down    (i_down),
        .i_left    (i_left),
        .i_right   (i_right),
        .i_on_log  (on_log),
        .i_respawn (respawn),
        .i_frozen  (frozen),
        .o_frog_x  (frog_x),
        .o_frog_y  (frog_y)
    );

    frogger_collisions #(.GAME_WIDTH(GAME_WIDTH)) u_coll (
        .i_frog_x   (frog_x),
        .i_frog_y   (frog_y),
        .hz         (haz.sink),
        .o_collided (collided),
        .o_on_log   (on_log)
    );

    frogger_game #(.START_LIVES(START_LIVES)) u_game (
        .i_Clk      (i_Clk),
        .i_rst_n    (i_rst_n),
        .i_start    (i_start),
        .i_collided (collided),
        .i_on_log   (on_log),
        .i_frog_y   (frog_y),
        .o_respawn  (respawn),
        .o_frozen   (frozen),
        .o_lives    (o_lives),
        .o_score    (o_score),
        .o_state    (o_state)
    );

    assign o_frog_x   = frog_x;
    assign o_frog_y   = frog_y;
    assign o_collided = collided;
    assign o_on_log   = on_log;

endmodule

`default_nettype wire

// ==== frogger_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module frogger_tb
    import frogger_pkg::*;
();

    localparam int W            = 14;
    localparam int LIVES        = 3;
    localparam int RESET_CYCLES = 3;
    localparam int N_RAND       = 40;

    // One stimulus code per cycle
    typedef enum int {C_IDLE, C_TICK, C_UP, C_DOWN, C_LEFT, C_RIGHT, C_START} stim_t;

    logic             clk;
    logic             rst_n;
    logic             tick;
    logic             up;
    logic             down;
    logic             left;
    logic             right;
    logic             start;
    logic [POS_W-1:0] frog_x;
    logic [POS_W-1:0] frog_y;
    logic             collided;
    logic             on_log;
    logic [1:0]       lives;
    logic [7:0]       score;
    game_state_t      state;

    // Step table of name, code and repeat count
    string t_name [$];
    stim_t t_code [$];
    int    t_count [$];
    bit    table_ready;

    // Reference model of the field
    int          m_car [NUM_CARS];
    int          m_log [NUM_LOGS];
    int          m_fx;
    int          m_fy;
    int          m_lives;
    int          m_score;
    game_state_t m_state;

    int          errors;
    int          checks;
    int          ntests;
    int          test_err;
    logic [31:0] lfsr;

    frogger_top #(.GAME_WIDTH(W), .START_LIVES(LIVES)) DUT (
        .i_Clk      (clk),
        .i_rst_n    (rst_n),
        .i_tick     (tick),
        .i_up       (up),
        .i_down     (down),
        .i_left     (left),
        .i_right    (right),
        .i_start    (start),
        .o_frog_x   (frog_x),
        .o_frog_y   (frog_y),
        .o_collided (collided),
        .o_on_log   (on_log),
        .o_lives    (lives),
        .o_score    (score),
        .o_state    (state)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    // Car on the frog row one tile to either side
    function automatic bit car_hit_now();
        bit hit;
        hit = 1'b0;
        for (int c = 0; c < NUM_CARS; c++) begin
            if (m_fy == CAR_Y_INIT[c] &&
                (m_fx == (m_car[c] + 1) % W || m_fx == (m_car[c] + W - 1) % W)) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    // Log covers its leading tile and two behind
    function automatic bit log_under_now();
        bit sup;
        sup = 1'b0;
        for (int l = 0; l < NUM_LOGS; l++) begin
            for (int k = 0; k < LOG_LEN; k++) begin
                if (m_fy == LOG_Y_INIT[l] && m_fx == (m_log[l] + W - k) % W) begin
                    sup = 1'b1;
                end
            end
        end
        return sup;
    endfunction

    task automatic model_reset();
        for (int c = 0; c < NUM_CARS; c++) m_car[c] = CAR_X_INIT[c];
        for (int l = 0; l < NUM_LOGS; l++) m_log[l] = LOG_X_INIT[l];
        m_fx    = W / 2;
        m_fy    = ROW_START;
        m_lives = LIVES;
        m_score = 0;
        m_state = ST_PLAY;
    endtask

    // One clock edge of the game rules
    task automatic model_step(input stim_t code);
        bit hit;
        bit ride;
        bit dead;
        bit goal;
        bit resp;
        hit  = car_hit_now();
        ride = log_under_now();
        dead = hit || (m_fy >= ROW_RIVER_LO && m_fy <= ROW_RIVER_HI && !ride);
        goal = (m_fy == ROW_GOAL);
        case (m_state)
            ST_PLAY: resp = goal && !dead;
            ST_DEAD: resp = (m_lives != 0);
            default: resp = (code == C_START);
        endcase
        // Respawn first, then buttons, then the log ride
        if (resp) begin
            m_fx = W / 2;
            m_fy = ROW_START;
        end else if (m_state != ST_OVER) begin
            case (code)
                C_UP:    if (m_fy < ROW_TOP) m_fy++;
                C_DOWN:  if (m_fy > ROW_START) m_fy--;
                C_LEFT:  if (m_fx > 0) m_fx--;
                C_RIGHT: if (m_fx < W - 1) m_fx++;
                C_TICK:  if (ride) m_fx = (m_fx + 1) % W;
                default: ;
            endcase
        end
        if (code == C_TICK) begin
            for (int c = 0; c < NUM_CARS; c++) m_car[c] = (m_car[c] + 1) % W;
            for (int l = 0; l < NUM_LOGS; l++) m_log[l] = (m_log[l] + 1) % W;
        end
        case (m_state)
            ST_PLAY: begin
                if (dead) begin
                    m_state = ST_DEAD;
                    m_lives = m_lives - 1;
                end else if (goal) begin
                    m_score = (m_score + 1) % 256;
                end
            end
            ST_DEAD: m_state = (m_lives == 0) ? ST_OVER : ST_PLAY;
            default: begin
                if (code == C_START) begin
                    m_state = ST_PLAY;
                    m_lives = LIVES;
                    m_score = 0;
                end
            end
        endcase
    endtask

    task automatic check_value(input string test, input string field,
                               input int expected, input int actual);
        checks++;
        if (expected != actual) begin
            $display("FAILED %s %s expected %0d actual %0d", test, field, expected, actual);
            errors++;
            test_err++;
        end
    endtask

    // Combinational hazard flags against the model positions
    task automatic compare_flags(input string name);
        check_value(name, "collided", car_hit_now(), collided);
        check_value(name, "on_log", log_under_now(), on_log);
    endtask

    task automatic compare_all(input string name);
        check_value(name, "frog_x", m_fx, frog_x);
        check_value(name, "frog_y", m_fy, frog_y);
        check_value(name, "lives", m_lives, lives);
        check_value(name, "score", m_score, score);
        check_value(name, "state", int'(m_state), int'(state));
        compare_flags(name);
    endtask

    // Called 5 ns after an edge, returns 5 ns after the next one
    task automatic run_cycle(input stim_t code);
        tick  = (code == C_TICK);
        up    = (code == C_UP);
        down  = (code == C_DOWN);
        left  = (code == C_LEFT);
        right = (code == C_RIGHT);
        start = (code == C_START);
        model_step(code);
        @(posedge clk);
        #5;
    endtask

    task automatic report_test(input string name);
        ntests++;
        if (test_err == 0) $display("test %s: ok", name);
        else $display("test %s: %0d mismatches", name, test_err);
    endtask

    // Two idle cycles let a death or respawn settle
    task automatic run_test(input string name, input stim_t code, input int count);
        test_err = 0;
        repeat (count) run_cycle(code);
        // Flags while the frog still sits where the step left it
        compare_flags(name);
        repeat (2) run_cycle(C_IDLE);
        compare_all(name);
        report_test(name);
    endtask

    task automatic add_step(input string name, input stim_t code, input int count);
        t_name.push_back(name);
        t_code.push_back(code);
        t_count.push_back(count);
    endtask

    task automatic load_table();
        add_step("reset", C_IDLE, 1);
        add_step("move_up", C_UP, 1);
        add_step("move_down", C_DOWN, 1);
        add_step("move_left", C_LEFT, 1);
        add_step("move_right", C_RIGHT, 1);
        add_step("left_edge", C_LEFT, 10);
        add_step("right_edge", C_RIGHT, 15);
        add_step("recenter", C_LEFT, 6);
        // Six ticks put the row 1 car next to column 7
        add_step("car_wait", C_TICK, 6);
        add_step("car_hit", C_UP, 1);
        // Column 6 clears every car and lands on the row 7 log
        add_step("log_shift", C_LEFT, 1);
        add_step("log_board", C_UP, 7);
        add_step("log_ride", C_TICK, 4);
        add_step("log_wrap", C_TICK, 4);
        add_step("drown_first", C_UP, 1);
        add_step("drown_shift", C_LEFT, 1);
        add_step("drown_last", C_UP, 7);
        // Buttons stay frozen after game over
        add_step("frozen_up", C_UP, 2);
        add_step("frozen_left", C_LEFT, 2);
        add_step("restart", C_START, 1);
        add_step("cross_shift", C_LEFT, 1);
        add_step("cross_road", C_UP, 6);
        add_step("cross_bank", C_LEFT, 4);
        add_step("cross_log", C_UP, 1);
        add_step("cross_river", C_UP, 1);
    endtask

    initial begin
        int code_val;
        tick     = 1'b0;
        up       = 1'b0;
        down     = 1'b0;
        left     = 1'b0;
        right    = 1'b0;
        start    = 1'b0;
        rst_n    = 1'b0;
        lfsr     = 32'h9963;
        errors   = 0;
        checks   = 0;
        ntests   = 0;
        test_err = 0;
        load_table();
        table_ready = 1'b1;
        model_reset();
        repeat (RESET_CYCLES) @(posedge clk);
        #5;
        rst_n = 1'b1;
        for (int i = 0; i < t_name.size(); i++) begin
            run_test(t_name[i], t_code[i], t_count[i]);
        end
        // Three LFSR bits pick each random code
        test_err = 0;
        for (int n = 0; n < N_RAND; n++) begin
            code_val = 0;
            for (int b = 0; b < 3; b++) begin
                lfsr     = lfsr_step(lfsr);
                code_val = code_val * 2 + lfsr[0];
            end
            run_cycle(stim_t'(code_val % 7));
            compare_flags("random_run");
            repeat (2) run_cycle(C_IDLE);
            compare_all("random_run");
        end
        report_test("random_run");
        $display("tests %0d, checks %0d, errors %0d", ntests, checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    // Four cycles per step is ample for a step plus its settle cycles
    initial begin
        int steps;
        wait (table_ready);
        steps = N_RAND;
        for (int i = 0; i < t_count.size(); i++) steps += t_count[i];
        #((steps * 4 + RESET_CYCLES + 4) * 100);
        $display("Watchdog expired before the tests finished, the run hung");
        $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
frogger_pkg.sv
hazard_if.sv
hazard_mover.sv
frog_control.sv
frogger_collisions.sv
frogger_game.sv
frogger_top.sv
frogger_tb.sv
